//--- include/periph_defs.svh
// Register map of the peripheral cluster. The offsets assume a 5-bit local address
// and the fixed 8-bit data word; changing the word size is not supported.
`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

`define PERIPH_WORD     8
`define PERIPH_ADDR_W   8
`define PERIPH_OFF_W    5
`define PERIPH_BASE     8'hEE
`define PERIPH_SPAN     18

// Interrupt controller.
`define EXTI_MASK       5'd0
`define EXTI_PEND       5'd1
`define EXTI_SOFT       5'd2

// GPIO.
`define GPI_LO          5'd3
`define GPI_HI          5'd4
`define GPO_LO          5'd5
`define GPO_HI          5'd6
`define GPIE_LO         5'd7
`define GPIE_HI         5'd8
`define GPCHG_LO        5'd9
`define GPCHG_HI        5'd10

// Timer.
`define TMR_PRESC       5'd11
`define TMR_PERIOD      5'd12
`define TMR_CTRL        5'd13

// UART.
`define UART_DATA       5'd14
`define UART_STAT       5'd15
`define UART_DIV        5'd16
`define UART_CTRL       5'd17
`define UART_DIV_RESET  8'd7

`endif

//--- source/periph_pkg.sv
// Shared types of the peripheral cluster.
// Pending-bit positions are fixed; software relies on them.
package periph_pkg;

    // Bit positions in EXTI_PEND, EXTI_MASK and ext_int.
    typedef enum logic [1:0] {
        IRQ_GPIO  = 2'd0,
        IRQ_TIMER = 2'd1,
        IRQ_UART  = 2'd2,
        IRQ_SOFT  = 2'd3
    } irq_src_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } uart_tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } uart_rx_state_e;

endpackage

//--- source/periph_bus_if.sv
// Decoded local bus inside the cluster. sel already includes enable and the window check.
`include "periph_defs.svh"

interface periph_bus_if (
    input logic clk
);
    logic                     sel;      // Access falls inside the window.
    logic [`PERIPH_OFF_W-1:0] offset;   // Address minus the window base.
    logic [`PERIPH_WORD-1:0]  wdata;
    logic                     write_en;

    modport ctrl (
        input  clk,
        output sel,
        output offset,
        output wdata,
        output write_en
    );

    modport dev (
        input clk,
        input sel,
        input offset,
        input wdata,
        input write_en
    );

endinterface

//--- source/periph_exti.sv
// Interrupt controller. Sources are level inputs and latch on their rising edge;
// a source held high sets its pending bit only once.
`include "periph_defs.svh"

module periph_exti
    import periph_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    periph_bus_if.dev               bus,
    output logic [`PERIPH_WORD-1:0] rdata,
    input  logic                    irq_gpio,
    input  logic                    irq_timer,
    input  logic                    irq_uart,
    output logic [3:0]              ext_int
);
    logic [3:0] src;
    logic [3:0] src_q;
    logic [3:0] set;
    logic [3:0] pend;
    logic [3:0] mask;
    logic       wr;

    assign wr = bus.sel && bus.write_en;

    always_comb begin
        src = '0;                                   // The soft slot has no level source.
        src[IRQ_GPIO]  = irq_gpio;
        src[IRQ_TIMER] = irq_timer;
        src[IRQ_UART]  = irq_uart;
        set = src & ~src_q;                         // Rising edges only.
        set[IRQ_SOFT] = wr && (bus.offset == `EXTI_SOFT) && bus.wdata[0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            src_q <= '0;
            pend  <= '0;
            mask  <= '0;
        end else begin
            src_q <= src;
            if (wr && bus.offset == `EXTI_MASK)
                mask <= bus.wdata[3:0];
            if (wr && bus.offset == `EXTI_PEND)
                pend <= (pend & ~bus.wdata[3:0]) | set;   // A new edge wins over the clear.
            else
                pend <= pend | set;
        end
    end

    assign ext_int = pend & mask;

    always_comb begin
        rdata = '0;
        if (bus.sel) begin
            case (bus.offset)
                `EXTI_MASK: rdata = `PERIPH_WORD'(mask);
                `EXTI_PEND: rdata = `PERIPH_WORD'(pend);
                default:    rdata = '0;            // EXTI_SOFT reads as zero.
            endcase
        end
    end

endmodule

//--- source/periph_gpio.sv
// 16-bit GPIO. Inputs pass a two-flop synchronizer, so pulses shorter than a clock
// may be missed; change flags compare consecutive synchronized samples.
`include "periph_defs.svh"

module periph_gpio (
    input  logic                    clk,
    input  logic                    rst_n,
    periph_bus_if.dev               bus,
    output logic [`PERIPH_WORD-1:0] rdata,
    input  logic [15:0]             gpi,
    output logic [15:0]             gpo,
    output logic                    irq
);
    logic [15:0] gpi_meta;
    logic [15:0] gpi_sync;
    logic [15:0] gpi_prev;
    logic [15:0] chg;
    logic [15:0] chg_clr;
    logic [15:0] ie;
    logic        wr;

    assign wr = bus.sel && bus.write_en;

    always_comb begin
        chg_clr = '0;
        if (wr && bus.offset == `GPCHG_LO)
            chg_clr[7:0] = bus.wdata;
        if (wr && bus.offset == `GPCHG_HI)
            chg_clr[15:8] = bus.wdata;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpi_meta <= '0;
            gpi_sync <= '0;
            gpi_prev <= '0;
            chg      <= '0;
            gpo      <= '0;
            ie       <= '0;
        end else begin
            gpi_meta <= gpi;
            gpi_sync <= gpi_meta;                   // Readable two edges after the pin.
            gpi_prev <= gpi_sync;
            chg      <= (chg & ~chg_clr) | (gpi_sync ^ gpi_prev);   // Set on the third edge.
            if (wr) begin
                case (bus.offset)
                    `GPO_LO:  gpo[7:0]  <= bus.wdata;
                    `GPO_HI:  gpo[15:8] <= bus.wdata;
                    `GPIE_LO: ie[7:0]   <= bus.wdata;
                    `GPIE_HI: ie[15:8]  <= bus.wdata;
                    default:  ;
                endcase
            end
        end
    end

    assign irq = |(chg & ie);

    always_comb begin
        rdata = '0;
        if (bus.sel) begin
            case (bus.offset)
                `GPI_LO:   rdata = gpi_sync[7:0];
                `GPI_HI:   rdata = gpi_sync[15:8];
                `GPO_LO:   rdata = gpo[7:0];
                `GPO_HI:   rdata = gpo[15:8];
                `GPIE_LO:  rdata = ie[7:0];
                `GPIE_HI:  rdata = ie[15:8];
                `GPCHG_LO: rdata = chg[7:0];
                `GPCHG_HI: rdata = chg[15:8];
                default:   rdata = '0;
            endcase
        end
    end

endmodule

//--- source/periph_timer.sv
// Down-counting timer with an 8-bit prescaler. PRESC and PERIOD changes take effect
// at the next reload; turning run on restarts both counters.
`include "periph_defs.svh"

module periph_timer (
    input  logic                    clk,
    input  logic                    rst_n,
    periph_bus_if.dev               bus,
    output logic [`PERIPH_WORD-1:0] rdata,
    output logic                    irq
);
    logic [7:0] presc;
    logic [7:0] period;
    logic [7:0] presc_cnt;
    logic [7:0] cnt;
    logic       run;
    logic       ie;
    logic       flag;
    logic       tick;
    logic       wr_ctrl;

    assign wr_ctrl = bus.sel && bus.write_en && (bus.offset == `TMR_CTRL);
    assign tick    = run && (presc_cnt == 8'd0);    // One tick every PRESC+1 clocks.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            presc     <= '0;
            period    <= '0;
            presc_cnt <= '0;
            cnt       <= '0;
            run       <= 1'b0;
            ie        <= 1'b0;
            flag      <= 1'b0;
        end else begin
            if (bus.sel && bus.write_en && bus.offset == `TMR_PRESC)
                presc <= bus.wdata;
            if (bus.sel && bus.write_en && bus.offset == `TMR_PERIOD)
                period <= bus.wdata;
            if (wr_ctrl) begin
                run <= bus.wdata[0];
                ie  <= bus.wdata[1];
                if (bus.wdata[7])
                    flag <= 1'b0;
            end
            if (wr_ctrl && bus.wdata[0] && !run) begin
                presc_cnt <= presc;                 // Start from a full interval.
                cnt       <= period;
            end else if (tick) begin
                presc_cnt <= presc;
                if (cnt == 8'd0) begin
                    cnt  <= period;
                    flag <= 1'b1;                   // Set wins over a clear in the same cycle.
                end else begin
                    cnt <= cnt - 8'd1;
                end
            end else if (run) begin
                presc_cnt <= presc_cnt - 8'd1;
            end
        end
    end

    assign irq = flag && ie;

    always_comb begin
        rdata = '0;
        if (bus.sel) begin
            case (bus.offset)
                `TMR_PRESC:  rdata = presc;
                `TMR_PERIOD: rdata = period;
                `TMR_CTRL:   rdata = {flag, 5'b0, ie, run};
                default:     rdata = '0;
            endcase
        end
    end

endmodule

//--- source/periph_uart.sv
// 8N1 UART with one byte of receive buffer. One bit lasts DIV+1 clocks; there is no
// parity and a frame with a low stop bit is discarded.
`include "periph_defs.svh"

module periph_uart
    import periph_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    periph_bus_if.dev               bus,
    output logic [`PERIPH_WORD-1:0] rdata,
    input  logic                    rx,
    output logic                    tx,
    output logic                    irq
);
    uart_tx_state_e tx_state;
    uart_rx_state_e rx_state;
    logic [7:0] div;
    logic [1:0] ctrl;
    logic [7:0] tx_cnt;
    logic [2:0] tx_bit;
    logic [7:0] tx_shift;
    logic       tx_q;
    logic       busy;
    logic       rx_meta;
    logic       rx_sync;
    logic [7:0] rx_cnt;
    logic [2:0] rx_bit;
    logic [7:0] rx_shift;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       overrun;
    logic       rx_done;
    logic       wr;
    logic       stat_clr;

    assign wr       = bus.sel && bus.write_en;
    assign stat_clr = wr && (bus.offset == `UART_STAT) && bus.wdata[1];
    assign busy     = (tx_state != TX_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div  <= `UART_DIV_RESET;
            ctrl <= '0;
        end else if (wr && bus.offset == `UART_DIV) begin
            div <= bus.wdata;
        end else if (wr && bus.offset == `UART_CTRL) begin
            ctrl <= bus.wdata[1:0];
        end
    end

    // Transmitter. A data write while busy is dropped.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_state <= TX_IDLE;
            tx_q     <= 1'b1;
        end else begin
            case (tx_state)
                TX_IDLE: if (wr && bus.offset == `UART_DATA) begin
                    tx_shift <= bus.wdata;
                    tx_cnt   <= div;
                    tx_q     <= 1'b0;               // Start bit begins at the write edge.
                    tx_state <= TX_START;
                end
                TX_START: if (tx_cnt == 8'd0) begin
                    tx_cnt   <= div;
                    tx_bit   <= '0;
                    tx_q     <= tx_shift[0];        // LSB first.
                    tx_state <= TX_DATA;
                end else begin
                    tx_cnt <= tx_cnt - 8'd1;
                end
                TX_DATA: if (tx_cnt == 8'd0) begin
                    tx_cnt <= div;
                    if (tx_bit == 3'd7) begin
                        tx_q     <= 1'b1;
                        tx_state <= TX_STOP;
                    end else begin
                        tx_shift <= tx_shift >> 1;
                        tx_q     <= tx_shift[1];
                        tx_bit   <= tx_bit + 3'd1;
                    end
                end else begin
                    tx_cnt <= tx_cnt - 8'd1;
                end
                default: if (tx_cnt == 8'd0) begin
                    tx_state <= TX_IDLE;            // Frame ends after the full stop bit.
                end else begin
                    tx_cnt <= tx_cnt - 8'd1;
                end
            endcase
        end
    end

    assign tx = tx_q;

    // Receiver samples at mid-bit, timed from the synchronized falling edge.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            rx_state <= RX_IDLE;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            case (rx_state)
                RX_IDLE: if (!rx_sync) begin
                    rx_cnt   <= div >> 1;
                    rx_state <= RX_START;
                end
                RX_START: if (rx_cnt == 8'd0) begin
                    rx_cnt   <= div;
                    rx_bit   <= '0;
                    rx_state <= rx_sync ? RX_IDLE : RX_DATA;   // A glitch is no start bit.
                end else begin
                    rx_cnt <= rx_cnt - 8'd1;
                end
                RX_DATA: if (rx_cnt == 8'd0) begin
                    rx_cnt   <= div;
                    rx_shift <= {rx_sync, rx_shift[7:1]};
                    rx_bit   <= rx_bit + 3'd1;
                    if (rx_bit == 3'd7)
                        rx_state <= RX_STOP;
                end else begin
                    rx_cnt <= rx_cnt - 8'd1;
                end
                default: if (rx_cnt == 8'd0) begin
                    rx_state <= RX_IDLE;
                    if (rx_sync)
                        rx_data <= rx_shift;
                end else begin
                    rx_cnt <= rx_cnt - 8'd1;
                end
            endcase
        end
    end

    assign rx_done = (rx_state == RX_STOP) && (rx_cnt == 8'd0) && rx_sync;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
            overrun  <= 1'b0;
        end else begin
            if (stat_clr) begin
                rx_valid <= 1'b0;
                overrun  <= 1'b0;
            end
            if (rx_done) begin
                rx_valid <= 1'b1;
                if (rx_valid && !stat_clr)
                    overrun <= 1'b1;                // Unread byte was overwritten.
            end
        end
    end

    assign irq = (rx_valid && ctrl[1]) || (!busy && ctrl[0]);

    always_comb begin
        rdata = '0;
        if (bus.sel) begin
            case (bus.offset)
                `UART_DATA: rdata = rx_data;
                `UART_STAT: rdata = {5'b0, overrun, rx_valid, busy};
                `UART_DIV:  rdata = div;
                `UART_CTRL: rdata = {6'b0, ctrl};
                default:    rdata = '0;
            endcase
        end
    end

endmodule

//--- source/periph_cluster.sv
// Peripheral cluster at `PERIPH_BASE. Reads are combinational and writes land on the
// next rising edge; the bus has no wait states.
`include "periph_defs.svh"

module periph_cluster (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      enable,
    input  logic [`PERIPH_ADDR_W-1:0] addr,
    input  logic [`PERIPH_WORD-1:0]   data_in,
    input  logic                      write_en,
    output logic [`PERIPH_WORD-1:0]   data_out,
    output logic [3:0]                ext_int,
    input  logic [15:0]               gpi,
    output logic [15:0]               gpo,
    input  logic                      rx,
    output logic                      tx
);
    logic [`PERIPH_ADDR_W-1:0] addr_rel;
    logic [`PERIPH_WORD-1:0]   rdata_exti;
    logic [`PERIPH_WORD-1:0]   rdata_gpio;
    logic [`PERIPH_WORD-1:0]   rdata_timer;
    logic [`PERIPH_WORD-1:0]   rdata_uart;
    logic                      irq_gpio;
    logic                      irq_timer;
    logic                      irq_uart;

    periph_bus_if bus (.clk(clk));

    // The upper bound is compared in 32 bits, so the window may end at 8'hFF.
    assign addr_rel     = addr - `PERIPH_BASE;
    assign bus.sel      = enable && (addr >= `PERIPH_BASE) && (addr < `PERIPH_BASE + `PERIPH_SPAN);
    assign bus.offset   = addr_rel[`PERIPH_OFF_W-1:0];
    assign bus.wdata    = data_in;
    assign bus.write_en = write_en;

    periph_exti u_exti (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus.dev),
        .rdata     (rdata_exti),
        .irq_gpio  (irq_gpio),
        .irq_timer (irq_timer),
        .irq_uart  (irq_uart),
        .ext_int   (ext_int)
    );

    periph_gpio u_gpio (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.dev),
        .rdata (rdata_gpio),
        .gpi   (gpi),
        .gpo   (gpo),
        .irq   (irq_gpio)
    );

    periph_timer u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.dev),
        .rdata (rdata_timer),
        .irq   (irq_timer)
    );

    periph_uart u_uart (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.dev),
        .rdata (rdata_uart),
        .rx    (rx),
        .tx    (tx),
        .irq   (irq_uart)
    );

    // Unselected blocks return zero.
    assign data_out = rdata_exti | rdata_gpio | rdata_timer | rdata_uart;

endmodule

//--- bench/periph_assert.sv
// Concurrent checks bound into the cluster. Reset is synchronous, so the reset-state
// checks look at the edge after rst_n is sampled low.
module periph_assert (
    input logic       clk,
    input logic       rst_n,
    input logic       enable,
    input logic [7:0] data_out,
    input logic [3:0] ext_int,
    input logic       tx
);
    timeunit 1ns;
    timeprecision 100ps;

    // Every block returns zero when the bus is not enabled.
    idle_read_zero: assert property (@(posedge clk) !enable |-> data_out == 8'h00)
        else $error("data_out is 0x%02h while enable is low", data_out);

    tx_high_in_reset: assert property (@(posedge clk) !rst_n |=> tx)
        else $error("tx is not high during reset");

    ext_int_clear_after_reset: assert property (@(posedge clk) !rst_n |=> ext_int == 4'h0)
        else $error("ext_int is 0x%01h right after reset", ext_int);

endmodule

bind periph_cluster periph_assert u_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .enable   (enable),
    .data_out (data_out),
    .ext_int  (ext_int),
    .tx       (tx)
);

//--- bench/periph_tb.sv
// Table-driven testbench for the peripheral cluster. tx is looped back to rx, and the
// random bytes come from a 32-bit Fibonacci LFSR with a fixed seed.
`include "periph_defs.svh"

module periph_tb
    import periph_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_WAIT_INT,
        OP_SET_GPI,
        OP_POLL,
        OP_IDLE,
        OP_GPO
    } op_e;

    // data holds the write value, the poll mask or the ext_int bit; exp the expected value.
    typedef struct packed {
        op_e         op;
        logic [2:0]  test;
        logic        en;
        logic [7:0]  addr;
        logic [15:0] data;
        logic [15:0] exp;
        logic [15:0] limit;
    } step_t;

    logic        clk;
    logic        rst_n;
    logic        enable;
    logic [7:0]  addr;
    logic [7:0]  data_in;
    logic        write_en;
    logic [7:0]  data_out;
    logic [3:0]  ext_int;
    logic [15:0] gpi;
    logic [15:0] gpo;
    logic        serial;                            // Shared tx and rx line.
    logic [31:0] lfsr = 32'h4b1a;
    step_t       steps[$];
    int          checks;
    int          errors;
    int          test_errors;

    periph_cluster dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .addr     (addr),
        .data_in  (data_in),
        .write_en (write_en),
        .data_out (data_out),
        .ext_int  (ext_int),
        .gpi      (gpi),
        .gpo      (gpo),
        .rx       (serial),
        .tx       (serial)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps at bits 32, 22, 2 and 1. The register steps once per bit taken.
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[14:0], fb};
        end
        return v;
    endfunction

    function automatic logic [7:0] reg_addr(input logic [4:0] off);
        return `PERIPH_BASE + 8'(off);
    endfunction

    function automatic void add_step(input op_e op, input logic [2:0] t, input logic en,
                                     input logic [7:0] a, input logic [15:0] d,
                                     input logic [15:0] e, input logic [15:0] lim);
        step_t s;
        s = '{op, t, en, a, d, e, lim};
        steps.push_back(s);
    endfunction

    function automatic string test_name(input logic [2:0] t);
        case (t)
            3'd1:    return "gpio in/out";
            3'd2:    return "window decode";
            3'd3:    return "gpio change irq";
            3'd4:    return "timer";
            3'd5:    return "uart loopback";
            default: return "soft irq";
        endcase
    endfunction

    function automatic void build_table();
        logic [7:0]  gpo_lo;
        logic [7:0]  gpo_hi;
        logic [15:0] gpi_val;
        logic [7:0]  tx_byte;
        int          k;
        gpo_lo  = 8'(rand_bits(8));
        gpo_hi  = 8'(rand_bits(8));
        gpi_val = rand_bits(16);
        add_step(OP_WRITE, 3'd1, 1'b1, reg_addr(`GPO_LO), {8'h00, gpo_lo}, 16'h0, 16'd0);
        add_step(OP_WRITE, 3'd1, 1'b1, reg_addr(`GPO_HI), {8'h00, gpo_hi}, 16'h0, 16'd0);
        add_step(OP_GPO, 3'd1, 1'b1, 8'h00, 16'h0, {gpo_hi, gpo_lo}, 16'd0);
        add_step(OP_READ, 3'd1, 1'b1, reg_addr(`GPO_LO), 16'h0, {8'h00, gpo_lo}, 16'd0);
        add_step(OP_READ, 3'd1, 1'b1, reg_addr(`GPO_HI), 16'h0, {8'h00, gpo_hi}, 16'd0);
        add_step(OP_SET_GPI, 3'd1, 1'b0, 8'h00, gpi_val, 16'h0, 16'd0);
        add_step(OP_IDLE, 3'd1, 1'b0, 8'h00, 16'h0, 16'h0, 16'd2);   // Synchronizer delay.
        add_step(OP_READ, 3'd1, 1'b1, reg_addr(`GPI_LO), 16'h0, {8'h00, gpi_val[7:0]}, 16'd0);
        add_step(OP_READ, 3'd1, 1'b1, reg_addr(`GPI_HI), 16'h0, {8'h00, gpi_val[15:8]}, 16'd0);
        add_step(OP_WRITE, 3'd2, 1'b1, 8'hED, {8'h00, ~gpo_lo}, 16'h0, 16'd0);
        add_step(OP_WRITE, 3'd2, 1'b0, reg_addr(`GPO_LO), {8'h00, ~gpo_lo}, 16'h0, 16'd0);
        add_step(OP_GPO, 3'd2, 1'b1, 8'h00, 16'h0, {gpo_hi, gpo_lo}, 16'd0);
        add_step(OP_READ, 3'd2, 1'b1, reg_addr(`GPO_LO), 16'h0, {8'h00, gpo_lo}, 16'd0);
        add_step(OP_READ, 3'd2, 1'b1, 8'hED, 16'h0, 16'h0, 16'd0);
        // 8'hD3 wraps to the GPO_LO offset if the lower window bound is not checked.
        add_step(OP_READ, 3'd2, 1'b1, 8'hD3, 16'h0, 16'h0, 16'd0);
        add_step(OP_READ, 3'd2, 1'b0, reg_addr(`GPO_LO), 16'h0, 16'h0, 16'd0);
        add_step(OP_WRITE, 3'd3, 1'b1, reg_addr(`GPCHG_LO), 16'hFF, 16'h0, 16'd0);
        add_step(OP_WRITE, 3'd3, 1'b1, reg_addr(`GPCHG_HI), 16'hFF, 16'h0, 16'd0);
        add_step(OP_WRITE, 3'd3, 1'b1, reg_addr(`GPIE_LO), 16'h01, 16'h0, 16'd0);
        add_step(OP_WRITE, 3'd3, 1'b1, reg_addr(`EXTI_MASK), 16'h01, 16'h0, 16'd0);
        add_step(OP_READ, 3'd3, 1'b1, reg_addr(`EXTI_PEND), 16'h0, 16'h00, 16'd0);
        add_step(OP_SET_GPI, 3'd3, 1'b0, 8'h00, gpi_val ^ 16'h0001, 16'h0, 16'd0);
        add_step(OP_WAIT_INT, 3'd3, 1'b0, 8'h00, 16'(IRQ_GPIO), 16'h1, 16'd10);
        add_step(OP_WRITE, 3'd3, 1'b1, reg_addr(`GPCHG_LO), 16'h01, 16'h0, 16'd0);
        add_step(OP_WRITE, 3'd3, 1'b1, reg_addr(`EXTI_PEND), 16'h01, 16'h0, 16'd0);
        add_step(OP_WAIT_INT, 3'd3, 1'b0, 8'h00, 16'(IRQ_GPIO), 16'h0, 16'd4);
        add_step(OP_READ, 3'd3, 1'b1, reg_addr(`EXTI_PEND), 16'h0, 16'h00, 16'd0);
        add_step(OP_WRITE, 3'd4, 1'b1, reg_addr(`TMR_PRESC), 16'h03, 16'h0, 16'd0);
        add_step(OP_WRITE, 3'd4, 1'b1, reg_addr(`TMR_PERIOD), 16'h05, 16'h0, 16'd0);
        add_step(OP_WRITE, 3'd4, 1'b1, reg_addr(`EXTI_MASK), 16'h02, 16'h0, 16'd0);
        add_step(OP_WRITE, 3'd4, 1'b1, reg_addr(`TMR_CTRL), 16'h03, 16'h0, 16'd0);
        add_step(OP_WAIT_INT, 3'd4, 1'b0, 8'h00, 16'(IRQ_TIMER), 16'h1, 16'd200);
        add_step(OP_READ, 3'd4, 1'b1, reg_addr(`TMR_CTRL), 16'h0, 16'h83, 16'd0);
        add_step(OP_WRITE, 3'd4, 1'b1, reg_addr(`TMR_CTRL), 16'h80, 16'h0, 16'd0);
        add_step(OP_READ, 3'd4, 1'b1, reg_addr(`TMR_CTRL), 16'h0, 16'h00, 16'd0);
        add_step(OP_WRITE, 3'd4, 1'b1, reg_addr(`EXTI_PEND), 16'h02, 16'h0, 16'd0);
        add_step(OP_WAIT_INT, 3'd4, 1'b0, 8'h00, 16'(IRQ_TIMER), 16'h0, 16'd4);
        add_step(OP_WRITE, 3'd5, 1'b1, reg_addr(`UART_CTRL), 16'h02, 16'h0, 16'd0);
        add_step(OP_WRITE, 3'd5, 1'b1, reg_addr(`EXTI_MASK), 16'h04, 16'h0, 16'd0);
        add_step(OP_READ, 3'd5, 1'b1, reg_addr(`UART_DIV), 16'h0, 16'(`UART_DIV_RESET), 16'd0);
        for (k = 0; k < 3; k++) begin
            tx_byte = 8'(rand_bits(8));
            add_step(OP_WRITE, 3'd5, 1'b1, reg_addr(`UART_DATA), {8'h00, tx_byte}, 16'h0, 16'd0);
            add_step(OP_POLL, 3'd5, 1'b1, reg_addr(`UART_STAT), 16'h02, 16'h02, 16'd200);
            add_step(OP_READ, 3'd5, 1'b1, reg_addr(`UART_DATA), 16'h0, {8'h00, tx_byte}, 16'd0);
            add_step(OP_WAIT_INT, 3'd5, 1'b0, 8'h00, 16'(IRQ_UART), 16'h1, 16'd8);
            add_step(OP_WRITE, 3'd5, 1'b1, reg_addr(`UART_STAT), 16'h02, 16'h0, 16'd0);
            add_step(OP_POLL, 3'd5, 1'b1, reg_addr(`UART_STAT), 16'h01, 16'h00, 16'd100);
            add_step(OP_WRITE, 3'd5, 1'b1, reg_addr(`EXTI_PEND), 16'h04, 16'h0, 16'd0);
            add_step(OP_WAIT_INT, 3'd5, 1'b0, 8'h00, 16'(IRQ_UART), 16'h0, 16'd4);
        end
        add_step(OP_WRITE, 3'd6, 1'b1, reg_addr(`EXTI_MASK), 16'h00, 16'h0, 16'd0);
        add_step(OP_WRITE, 3'd6, 1'b1, reg_addr(`EXTI_SOFT), 16'h01, 16'h0, 16'd0);
        add_step(OP_IDLE, 3'd6, 1'b0, 8'h00, 16'h0, 16'h0, 16'd2);
        add_step(OP_WAIT_INT, 3'd6, 1'b0, 8'h00, 16'(IRQ_SOFT), 16'h0, 16'd1);  // Masked out.
        add_step(OP_READ, 3'd6, 1'b1, reg_addr(`EXTI_PEND), 16'h0, 16'h08, 16'd0);
        add_step(OP_WRITE, 3'd6, 1'b1, reg_addr(`EXTI_MASK), 16'h08, 16'h0, 16'd0);
        add_step(OP_WAIT_INT, 3'd6, 1'b0, 8'h00, 16'(IRQ_SOFT), 16'h1, 16'd4);
        add_step(OP_WRITE, 3'd6, 1'b1, reg_addr(`EXTI_PEND), 16'h08, 16'h0, 16'd0);
        add_step(OP_WAIT_INT, 3'd6, 1'b0, 8'h00, 16'(IRQ_SOFT), 16'h0, 16'd4);
        add_step(OP_WRITE, 3'd6, 1'b1, reg_addr(`EXTI_SOFT), 16'h01, 16'h0, 16'd0);
        add_step(OP_WAIT_INT, 3'd6, 1'b0, 8'h00, 16'(IRQ_SOFT), 16'h1, 16'd4);
    endfunction

    function automatic void record_error();
        errors++;
        test_errors++;
    endfunction

    task automatic write_reg(input logic en, input logic [7:0] a, input logic [7:0] d);
        @(posedge clk);
        enable   <= en;
        write_en <= 1'b1;
        addr     <= a;
        data_in  <= d;
        @(posedge clk);                             // The DUT takes the write at this edge.
        enable   <= 1'b0;
        write_en <= 1'b0;
    endtask

    task automatic read_check(input logic en, input logic [7:0] a, input logic [7:0] exp);
        @(posedge clk);
        enable   <= en;
        write_en <= 1'b0;
        addr     <= a;
        @(negedge clk);
        checks++;
        if (data_out !== exp) begin
            record_error();
            $display("** Error at %0t: read 0x%02h from 0x%02h, expected 0x%02h",
                     $time, data_out, a, exp);
        end
    endtask

    task automatic poll_reg(input logic [7:0] a, input logic [7:0] mask, input logic [7:0] exp,
                            input int limit);
        int n;
        n = 0;
        @(posedge clk);
        enable   <= 1'b1;
        write_en <= 1'b0;
        addr     <= a;
        @(negedge clk);
        while (((data_out & mask) !== exp) && (n < limit)) begin
            @(negedge clk);
            n++;
        end
        checks++;
        if ((data_out & mask) !== exp) begin
            record_error();
            $display("Timeout at %0t: register 0x%02h never showed 0x%02h under mask 0x%02h",
                     $time, a, exp, mask);
        end
    endtask

    task automatic wait_int(input logic [1:0] b, input logic lvl, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while ((ext_int[b] !== lvl) && (n < limit)) begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (ext_int[b] !== lvl) begin
            record_error();
            $display("Timeout at %0t: ext_int[%0d] did not reach %0b within %0d cycles",
                     $time, b, lvl, limit);
        end
    endtask

    task automatic check_gpo(input logic [15:0] exp);
        @(negedge clk);
        checks++;
        if (gpo !== exp) begin
            record_error();
            $display("** Error at %0t: gpo is 0x%04h, expected 0x%04h", $time, gpo, exp);
        end
    endtask

    task automatic apply_step(input step_t s);
        case (s.op)
            OP_WRITE:    write_reg(s.en, s.addr, s.data[7:0]);
            OP_READ:     read_check(s.en, s.addr, s.exp[7:0]);
            OP_POLL:     poll_reg(s.addr, s.data[7:0], s.exp[7:0], int'(s.limit));
            OP_WAIT_INT: wait_int(s.data[1:0], s.exp[0], int'(s.limit));
            OP_SET_GPI: begin
                @(posedge clk);
                gpi <= s.data;
            end
            OP_IDLE: begin
                @(posedge clk);
                enable <= 1'b0;
                repeat (int'(s.limit) - 1) @(posedge clk);
            end
            default:     check_gpo(s.exp);
        endcase
    endtask

    task automatic report_test(input logic [2:0] t);
        $display("Test %0d (%s) done with %0d error(s)", t, test_name(t), test_errors);
    endtask

    initial begin
        step_t      s;
        logic [2:0] cur;
        $timeformat(-9, 1, " ns", 0);
        rst_n       = 1'b0;
        enable      = 1'b0;
        addr        = 8'h00;
        data_in     = 8'h00;
        write_en    = 1'b0;
        gpi         = 16'h0000;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        cur         = 3'd0;
        build_table();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        foreach (steps[i]) begin
            s = steps[i];
            if (s.test != cur) begin
                if (cur != 3'd0)
                    report_test(cur);
                cur         = s.test;
                test_errors = 0;
            end
            apply_step(s);
        end
        report_test(cur);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
source/periph_pkg.sv
source/periph_bus_if.sv
source/periph_exti.sv
source/periph_gpio.sv
source/periph_timer.sv
source/periph_uart.sv
source/periph_cluster.sv
bench/periph_assert.sv
bench/periph_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the peripheral cluster testbench with Verilator and runs it.
# Exits non-zero unless the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module periph_tb -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vperiph_tb)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
